//--- logic/core_cfg_pkg.sv
// Core configuration package
// Data width, ROB and register tags, PC width rule

package core_cfg_pkg;

    // Integer datapath width
    localparam int XLEN = 32;

    // Tag widths shared by rename and commit
    localparam int ROB_ID_W  = 6;
    localparam int REG_TAG_W = 6;

    // ROB entry tag
    typedef logic [ROB_ID_W-1:0] rob_id_t;

    // Physical destination register tag
    typedef logic [REG_TAG_W-1:0] reg_tag_t;

    // PC bits kept in the pipeline
    // Halfword PC with compressed ops, word PC without
    function automatic int pc_bits(input bit c_ext);
        int width;
        width = c_ext ? 31 : 30;
        return width;
    endfunction

    // Widest PC, used where both cases share one field
    // Top bit unused when the C extension is off
    typedef logic [pc_bits(1'b1)-1:0] pc_t;

    // Full byte address
    typedef logic [XLEN-1:0] xword_t;

endpackage

//--- logic/branch_pkg.sv
// Branch execution package
// Condition and kind encodings, issue, prediction, writeback and BTB update packets

package branch_pkg;

    // funct3 branch condition
    // Bit 0 negates, bit 1 unsigned, bit 2 magnitude compare
    typedef logic [2:0] bcond_t;

    // Bit positions inside bcond_t
    localparam int BC_NEG = 0;
    localparam int BC_UNS = 1;
    localparam int BC_MAG = 2;

    // Branch kind as held in the BTB
    typedef enum logic [1:0] {
        BT_COND = 2'b00,
        BT_CALL = 2'b01,
        BT_JUMP = 2'b10,
        BT_RET  = 2'b11
    } btype_t;

    // Issue packet for one control-flow micro-op
    typedef struct packed {
        core_cfg_pkg::xword_t   operand_1;
        core_cfg_pkg::xword_t   operand_2;
        core_cfg_pkg::xword_t   offset;
        core_cfg_pkg::pc_t      pc;
        logic                   auipc;
        logic                   call;
        logic                   ret;
        logic                   jal;
        logic                   jalr;
        bcond_t                 cond;
        logic                   ins_sz;     // 1 for a 16-bit op
        core_cfg_pkg::rob_id_t  rob_id;
        core_cfg_pkg::reg_tag_t dest;
    } bru_op_t;

    // Front-end prediction carried with the op
    typedef struct packed {
        logic              present;
        btype_t            btype;
        core_cfg_pkg::pc_t target;   // In PC units
        logic              way;
        logic [1:0]        bm_ctr;
    } btb_pred_t;

    // Writeback to the register file
    typedef struct packed {
        logic                   valid;
        core_cfg_pkg::reg_tag_t dest;
        core_cfg_pkg::xword_t   result;
        core_cfg_pkg::rob_id_t  rob_id;
    } wb_pkt_t;

    // Training packet for BTB, bimodal table and RAS
    typedef struct packed {
        core_cfg_pkg::pc_t    vpc;
        core_cfg_pkg::xword_t target;
        logic [1:0]           bm_ctr;
        logic                 taken;
        btype_t               btype;
        logic                 present;
        logic                 way;
        logic                 bm_mod;
        logic                 call_affirm;
        logic                 ret_affirm;
    } btb_upd_t;

endpackage

//--- logic/branch_compare.sv
// Branch condition evaluation
// One shared 31-bit magnitude compare serves both signed and unsigned cases
`timescale 1ns/100ps

module branch_compare (
    input  core_cfg_pkg::xword_t operand_1_i,
    input  core_cfg_pkg::xword_t operand_2_i,
    input  branch_pkg::bcond_t   cond_i,
    output logic                 taken_o
);

    logic eq;
    logic gt_low;
    logic s1;
    logic s2;
    logic gt_s;
    logic gt_u;
    logic gt;
    logic lt;
    logic base;

    assign eq     = operand_1_i == operand_2_i;
    assign gt_low = operand_1_i[30:0] > operand_2_i[30:0];
    assign s1     = operand_1_i[31];
    assign s2     = operand_2_i[31];

    // Signs differ: the positive one is larger when signed
    // and the one with the top bit set is larger when unsigned
    assign gt_s = (s1 != s2) ? s2 : gt_low;
    assign gt_u = (s1 != s2) ? s1 : gt_low;

    assign gt = cond_i[branch_pkg::BC_UNS] ? gt_u : gt_s;
    assign lt = !(gt | eq);

    // BEQ/BLT/BLTU base, negation gives BNE/BGE/BGEU
    assign base    = cond_i[branch_pkg::BC_MAG] ? lt : eq;
    assign taken_o = base ^ cond_i[branch_pkg::BC_NEG];

endmodule

//--- logic/branch_target.sv
// Branch target and link generation
// Also derives the fetch-block VPC used to key the BTB entry
`timescale 1ns/100ps

module branch_target #(
    parameter int   ENABLE_C_EXTENSION = 1,
    localparam int  PC_BITS = core_cfg_pkg::pc_bits(ENABLE_C_EXTENSION != 0)
) (
    input  branch_pkg::bru_op_t  op_i,
    input  logic                 taken_i,
    output core_cfg_pkg::xword_t target_o,
    output core_cfg_pkg::xword_t result_o,
    output logic [PC_BITS-1:0]   vpc_o
);

    core_cfg_pkg::xword_t pc_32;
    core_cfg_pkg::xword_t pc_const;
    core_cfg_pkg::xword_t pc_nx;
    core_cfg_pkg::xword_t base;
    core_cfg_pkg::xword_t addend;
    logic                 use_offset;

    // Byte address of the op
    assign pc_32 = (ENABLE_C_EXTENSION != 0) ? {op_i.pc, 1'b0} : {op_i.pc[29:0], 2'b00};

    // Instruction size, 2 only for compressed ops
    assign pc_const = ((ENABLE_C_EXTENSION != 0) && op_i.ins_sz) ? 32'd2 : 32'd4;

    // JALR is register relative, all else PC relative
    assign base = op_i.jalr ? op_i.operand_1 : pc_32;

    // Offset for jumps and taken branches, fall-through otherwise
    assign use_offset = (op_i.jal | op_i.jalr | taken_i) & !op_i.auipc;
    assign addend     = use_offset ? op_i.offset : pc_const;
    assign target_o   = base + addend;

    // Link address or AUIPC sum
    assign pc_nx    = pc_32 + pc_const;
    assign result_o = op_i.auipc ? pc_32 + op_i.offset : pc_nx;

    generate
        if (ENABLE_C_EXTENSION != 0) begin : g_vpc_half
            // A 16-bit op is keyed on the halfword after it
            // Last halfword of a block rolls over to the next block
            always_comb begin
                if (!op_i.ins_sz) begin
                    vpc_o = op_i.pc;
                end else begin
                    case (op_i.pc[1:0])
                        2'b00:   vpc_o = {op_i.pc[30:2], 2'b01};
                        2'b01:   vpc_o = {op_i.pc[30:2], 2'b10};
                        2'b10:   vpc_o = {op_i.pc[30:2], 2'b11};
                        default: vpc_o = {pc_nx[31:3], 2'b00};
                    endcase
                end
            end
        end else begin : g_vpc_word
            // Word PC keys the entry directly
            assign vpc_o = op_i.pc[PC_BITS-1:0];
        end
    endgenerate

endmodule

//--- logic/branch_unit.sv
// Branch resolution stage
// Checks the BTB prediction, raises redirects and registers writeback and training
`timescale 1ns/100ps

module branch_unit #(
    parameter int   ENABLE_C_EXTENSION = 1,
    localparam int  PC_BITS = core_cfg_pkg::pc_bits(ENABLE_C_EXTENSION != 0)
) (
    input  logic                   cpu_clock_i,
    input  logic                   arst_n_i,
    input  logic                   valid_i,
    input  logic                   flush_i,
    input  branch_pkg::bru_op_t    op_i,
    input  branch_pkg::btb_pred_t  pred_i,
    input  logic                   taken_i,
    input  core_cfg_pkg::xword_t   target_i,
    input  core_cfg_pkg::xword_t   result_i,
    input  logic [PC_BITS-1:0]     vpc_i,
    output branch_pkg::wb_pkt_t    wb_o,
    output logic                   res_valid_o,
    output core_cfg_pkg::rob_id_t  rob_o,
    output logic                   excp_o,
    output branch_pkg::btb_upd_t   upd_o
);

    branch_pkg::btype_t btype;
    core_cfg_pkg::pc_t  pred_tgt;
    logic               go;
    logic               redirect;
    logic               miss_hit;
    logic               wrong_tgt;
    logic               wrong_type;
    logic               wrong_dir;
    logic               mispredict;
    logic               hit_ok;

    // Control state, reset
    logic wb_valid_q;
    logic bm_mod_q;
    logic call_q;
    logic ret_q;

    // Payload, not reset
    core_cfg_pkg::reg_tag_t dest_q;
    core_cfg_pkg::xword_t   result_q;
    core_cfg_pkg::pc_t      vpc_q;
    core_cfg_pkg::xword_t   target_q;
    logic [1:0]             bm_ctr_q;
    logic                   taken_q;
    branch_pkg::btype_t     btype_q;
    logic                   way_q;

    assign btype = op_i.call ? branch_pkg::BT_CALL :
                   op_i.ret  ? branch_pkg::BT_RET  :
                   (op_i.jal | op_i.jalr) ? branch_pkg::BT_JUMP : branch_pkg::BT_COND;

    assign go = valid_i & !flush_i;

    // AUIPC never leaves the sequential path
    assign redirect = !op_i.auipc & (taken_i | (btype != branch_pkg::BT_COND));

    // Predicted target back in halfword units for the compare
    assign pred_tgt = (ENABLE_C_EXTENSION != 0) ? pred_i.target :
                      {pred_i.target[29:0], 1'b0};

    // The four ways a prediction can be wrong
    assign miss_hit   = !pred_i.present & redirect;
    assign wrong_tgt  = pred_i.present & (pred_tgt != target_i[31:1]);
    assign wrong_type = pred_i.present & (btype != pred_i.btype);
    assign wrong_dir  = pred_i.present & (btype == branch_pkg::BT_COND) &
                        (redirect ^ pred_i.bm_ctr[1]);
    assign mispredict = miss_hit | wrong_tgt | wrong_type | wrong_dir;
    assign hit_ok     = pred_i.present & !mispredict;

    always_ff @(posedge cpu_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_q  <= 1'b0;
            res_valid_o <= 1'b0;
            excp_o      <= 1'b0;
            bm_mod_q    <= 1'b0;
            call_q      <= 1'b0;
            ret_q       <= 1'b0;
        end else begin
            // Only jumps and AUIPC write a register, never x0
            wb_valid_q  <= go & (op_i.auipc | op_i.jal | op_i.jalr) & (op_i.dest != '0);
            res_valid_o <= go;
            excp_o      <= go & mispredict;
            // Training only on a fully correct hit
            bm_mod_q    <= go & hit_ok & !(op_i.call | op_i.ret);
            call_q      <= go & hit_ok & op_i.call;
            ret_q       <= go & hit_ok & op_i.ret;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        dest_q   <= op_i.dest;
        result_q <= result_i;
        rob_o    <= op_i.rob_id;
        vpc_q    <= core_cfg_pkg::pc_t'(vpc_i);
        target_q <= target_i;
        bm_ctr_q <= pred_i.bm_ctr;
        taken_q  <= redirect;
        btype_q  <= btype;
        way_q    <= pred_i.way;
    end

    assign wb_o = '{valid: wb_valid_q, dest: dest_q, result: result_q, rob_id: rob_o};

    // Present follows taken so a not-taken branch never allocates
    assign upd_o = '{
        vpc:         vpc_q,
        target:      target_q,
        bm_ctr:      bm_ctr_q,
        taken:       taken_q,
        btype:       btype_q,
        present:     taken_q,
        way:         way_q,
        bm_mod:      bm_mod_q,
        call_affirm: call_q,
        ret_affirm:  ret_q
    };

    // A redirect and a training strobe for the same op would corrupt the BTB
    a_excp_no_strobe: assert property (@(posedge cpu_clock_i) disable iff (!arst_n_i)
        excp_o |-> !(upd_o.bm_mod | upd_o.call_affirm | upd_o.ret_affirm));

    // RAS sees at most one affirm per op
    a_one_affirm: assert property (@(posedge cpu_clock_i) disable iff (!arst_n_i)
        !(upd_o.call_affirm & upd_o.ret_affirm));

    // Flushed ops leave no trace
    a_flush_quiet: assert property (@(posedge cpu_clock_i) disable iff (!arst_n_i)
        flush_i |=> !(res_valid_o | wb_o.valid | excp_o | upd_o.bm_mod |
                      upd_o.call_affirm | upd_o.ret_affirm));

endmodule

//--- logic/bimodal_table.sv
// Bimodal direction predictor
// 2-bit saturating counters, combinational read, write on update strobe
`timescale 1ns/100ps

module bimodal_table #(
    parameter int   BM_ENTRIES = 16,
    localparam int  IDX_W = $clog2(BM_ENTRIES)
) (
    input  logic             cpu_clock_i,
    input  logic             arst_n_i,
    input  logic [IDX_W-1:0] rd_idx_i,
    output logic [1:0]       rd_ctr_o,
    input  logic             wr_en_i,
    input  logic [IDX_W-1:0] wr_idx_i,
    input  logic [1:0]       wr_ctr_i,
    input  logic             wr_taken_i
);

    logic [1:0] ctr_q [BM_ENTRIES];
    logic [1:0] ctr_nx;

    // Step the predicted value toward the outcome
    always_comb begin
        if (wr_taken_i) begin
            ctr_nx = (wr_ctr_i == 2'b11) ? 2'b11 : wr_ctr_i + 2'b01;
        end else begin
            ctr_nx = (wr_ctr_i == 2'b00) ? 2'b00 : wr_ctr_i - 2'b01;
        end
    end

    // All entries start weakly not-taken
    always_ff @(posedge cpu_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < BM_ENTRIES; i++) begin
                ctr_q[i] <= 2'b01;
            end
        end else if (wr_en_i) begin
            ctr_q[wr_idx_i] <= ctr_nx;
        end
    end

    // No bypass, a write shows up on the next read
    assign rd_ctr_o = ctr_q[rd_idx_i];

    // Non power-of-two tables leave indices past the end
    a_wr_idx_range: assert property (@(posedge cpu_clock_i) disable iff (!arst_n_i)
        wr_en_i |-> (int'(wr_idx_i) < BM_ENTRIES));

endmodule

//--- logic/branch_exec_top.sv
// Branch execution subsystem
// Compare, target, resolution and bimodal table with the training loop closed
`timescale 1ns/100ps

module branch_exec_top #(
    parameter int   ENABLE_C_EXTENSION = 1,
    parameter int   BM_ENTRIES = 16,
    localparam int  PC_BITS = core_cfg_pkg::pc_bits(ENABLE_C_EXTENSION != 0),
    localparam int  IDX_W = $clog2(BM_ENTRIES)
) (
    input  logic                   cpu_clock_i,
    input  logic                   arst_n_i,
    input  logic                   valid_i,
    input  logic                   flush_i,
    input  branch_pkg::bru_op_t    op_i,
    input  branch_pkg::btb_pred_t  pred_i,
    output branch_pkg::wb_pkt_t    wb_o,
    output logic                   res_valid_o,
    output core_cfg_pkg::rob_id_t  rob_o,
    output logic                   excp_o,
    output branch_pkg::btb_upd_t   upd_o,
    output logic [1:0]             bm_ctr_o
);

    logic                  taken;
    core_cfg_pkg::xword_t  target;
    core_cfg_pkg::xword_t  result;
    logic [PC_BITS-1:0]    vpc;
    branch_pkg::btb_pred_t pred_bm;

    // Direction comes from the local table, not the front end
    assign pred_bm = '{present: pred_i.present, btype: pred_i.btype,
                       target: pred_i.target, way: pred_i.way, bm_ctr: bm_ctr_o};

    branch_compare branch_compare_i (
        .operand_1_i (op_i.operand_1),
        .operand_2_i (op_i.operand_2),
        .cond_i      (op_i.cond),
        .taken_o     (taken)
    );

    branch_target #(.ENABLE_C_EXTENSION(ENABLE_C_EXTENSION)) branch_target_i (
        .op_i     (op_i),
        .taken_i  (taken),
        .target_o (target),
        .result_o (result),
        .vpc_o    (vpc)
    );

    branch_unit #(.ENABLE_C_EXTENSION(ENABLE_C_EXTENSION)) branch_unit_i (
        .cpu_clock_i (cpu_clock_i),
        .arst_n_i    (arst_n_i),
        .valid_i     (valid_i),
        .flush_i     (flush_i),
        .op_i        (op_i),
        .pred_i      (pred_bm),
        .taken_i     (taken),
        .target_i    (target),
        .result_i    (result),
        .vpc_i       (vpc),
        .wb_o        (wb_o),
        .res_valid_o (res_valid_o),
        .rob_o       (rob_o),
        .excp_o      (excp_o),
        .upd_o       (upd_o)
    );

    // Read by issuing PC, trained by the registered update
    bimodal_table #(.BM_ENTRIES(BM_ENTRIES)) bimodal_table_i (
        .cpu_clock_i (cpu_clock_i),
        .arst_n_i    (arst_n_i),
        .rd_idx_i    (op_i.pc[IDX_W-1:0]),
        .rd_ctr_o    (bm_ctr_o),
        .wr_en_i     (upd_o.bm_mod),
        .wr_idx_i    (upd_o.vpc[IDX_W-1:0]),
        .wr_ctr_i    (upd_o.bm_ctr),
        .wr_taken_i  (upd_o.taken)
    );

endmodule

//--- dv/branch_model.svh
// Reference model for the branch execution subsystem
// Predicts writeback, resolution and BTB training one cycle after issue
`ifndef BRANCH_MODEL_SVH
`define BRANCH_MODEL_SVH

// Everything the DUT shows for one sampled op
typedef struct packed {
    branch_pkg::wb_pkt_t   wb;
    logic                  res_valid;
    core_cfg_pkg::rob_id_t rob;
    logic                  excp;
    branch_pkg::btb_upd_t  upd;
} expect_t;

// RISC-V funct3 branch conditions
function automatic logic cond_taken(core_cfg_pkg::xword_t a, core_cfg_pkg::xword_t b,
                                    branch_pkg::bcond_t c);
    logic r;
    case (c)
        3'b000:  r = (a == b);
        3'b001:  r = (a != b);
        3'b100:  r = ($signed(a) < $signed(b));
        3'b101:  r = ($signed(a) >= $signed(b));
        3'b110:  r = (a < b);
        3'b111:  r = (a >= b);
        default: r = 1'b0;
    endcase
    return r;
endfunction

// Call and return win over plain jumps
function automatic branch_pkg::btype_t branch_kind(branch_pkg::bru_op_t o);
    if (o.call) begin
        return branch_pkg::BT_CALL;
    end
    if (o.ret) begin
        return branch_pkg::BT_RET;
    end
    if (o.jal || o.jalr) begin
        return branch_pkg::BT_JUMP;
    end
    return branch_pkg::BT_COND;
endfunction

// Halfword PC with compressed ops enabled
function automatic core_cfg_pkg::xword_t byte_pc(branch_pkg::bru_op_t o);
    return {o.pc, 1'b0};
endfunction

function automatic core_cfg_pkg::xword_t op_size(branch_pkg::bru_op_t o);
    return o.ins_sz ? 32'd2 : 32'd4;
endfunction

function automatic core_cfg_pkg::xword_t resolve_target(branch_pkg::bru_op_t o, logic tk);
    core_cfg_pkg::xword_t base;
    base = o.jalr ? o.operand_1 : byte_pc(o);
    // AUIPC is no branch, it falls through
    if (!o.auipc && (o.jal || o.jalr || tk)) begin
        return base + o.offset;
    end
    return base + op_size(o);
endfunction

function automatic core_cfg_pkg::xword_t link_result(branch_pkg::bru_op_t o);
    return o.auipc ? byte_pc(o) + o.offset : byte_pc(o) + op_size(o);
endfunction

// 16-bit op keyed on the halfword after it, wrapping into the next block
function automatic core_cfg_pkg::pc_t block_vpc(branch_pkg::bru_op_t o);
    return o.ins_sz ? o.pc + 31'd1 : o.pc;
endfunction

// Saturating 2-bit step toward the outcome
function automatic logic [1:0] ctr_step(logic [1:0] c, logic t);
    if (t) begin
        return (c == 2'b11) ? c : c + 2'b01;
    end
    return (c == 2'b00) ? c : c - 2'b01;
endfunction

function automatic expect_t expect_op(branch_pkg::bru_op_t o, branch_pkg::btb_pred_t p,
                                      logic [1:0] ctr, logic v, logic f);
    expect_t              e;
    logic                 go;
    logic                 redir;
    logic                 wrong;
    logic                 good_hit;
    branch_pkg::btype_t   kind;
    core_cfg_pkg::xword_t tgt;
    go    = v && !f;
    kind  = branch_kind(o);
    tgt   = resolve_target(o, cond_taken(o.operand_1, o.operand_2, o.cond));
    redir = !o.auipc && (cond_taken(o.operand_1, o.operand_2, o.cond) ||
                         kind != branch_pkg::BT_COND);
    // Missing hit, target, type, then direction from the table
    wrong = (!p.present && redir) ||
            (p.present && p.target != tgt[31:1]) ||
            (p.present && p.btype != kind) ||
            (p.present && kind == branch_pkg::BT_COND && redir != ctr[1]);
    good_hit = p.present && !wrong;
    e.wb.valid         = go && (o.auipc || o.jal || o.jalr) && (o.dest != '0);
    e.wb.dest          = o.dest;
    e.wb.result        = link_result(o);
    e.wb.rob_id        = o.rob_id;
    e.res_valid        = go;
    e.rob              = o.rob_id;
    e.excp             = go && wrong;
    e.upd.vpc          = block_vpc(o);
    e.upd.target       = tgt;
    e.upd.bm_ctr       = ctr;
    e.upd.taken        = redir;
    e.upd.btype        = kind;
    e.upd.present      = redir;
    e.upd.way          = p.way;
    e.upd.bm_mod       = go && good_hit && !o.call && !o.ret;
    e.upd.call_affirm  = go && good_hit && o.call;
    e.upd.ret_affirm   = go && good_hit && o.ret;
    return e;
endfunction

`endif

//--- dv/branch_exec_tb.sv
// Testbench for the branch execution subsystem
// Seeded random ops checked every cycle against the reference model
`timescale 1ns/100ps

module branch_exec_tb;

    localparam int RST_CYCLES = 16;
    localparam int N_RAND     = 400;
    localparam int N_SAT      = 8;
    localparam int N_STEPS    = N_RAND + 2 * (2 * N_SAT + 3) + 8 + 1;

    `include "branch_model.svh"

    logic                  cpu_clock;
    logic                  arst_n;
    logic                  valid;
    logic                  flush;
    branch_pkg::bru_op_t   op;
    branch_pkg::btb_pred_t pred;
    branch_pkg::wb_pkt_t   wb;
    logic                  res_valid;
    core_cfg_pkg::rob_id_t rob;
    logic                  excp;
    branch_pkg::btb_upd_t  upd;
    logic [1:0]            bm_ctr;

    // Shadow of the counter table
    logic [1:0] shadow [16];
    expect_t    prev_exp;
    bit         have_prev;
    int         err_count;

    branch_exec_top #(.ENABLE_C_EXTENSION(1), .BM_ENTRIES(16)) branch_exec_top_i (
        .cpu_clock_i (cpu_clock),
        .arst_n_i    (arst_n),
        .valid_i     (valid),
        .flush_i     (flush),
        .op_i        (op),
        .pred_i      (pred),
        .wb_o        (wb),
        .res_valid_o (res_valid),
        .rob_o       (rob),
        .excp_o      (excp),
        .upd_o       (upd),
        .bm_ctr_o    (bm_ctr)
    );

    always #10 cpu_clock = ~cpu_clock;

    task automatic abort_run();
        err_count++;
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic wb_check(input branch_pkg::wb_pkt_t got, input branch_pkg::wb_pkt_t exp,
                            input string name);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic upd_check(input branch_pkg::btb_upd_t got, input branch_pkg::btb_upd_t exp,
                             input string name);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic flag_check(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic rob_check(input core_cfg_pkg::rob_id_t got, input core_cfg_pkg::rob_id_t exp,
                             input string name);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic ctr_check(input logic [1:0] got, input logic [1:0] exp, input string name);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Kind 0 cond, 1 jal, 2 jalr, 3 auipc, 4 call, 5 return
    function automatic branch_pkg::bru_op_t random_op(int kind);
        branch_pkg::bru_op_t o;
        int                  c;
        o = '0;
        o.operand_1 = $urandom;
        o.operand_2 = ($urandom_range(3) == 0) ? o.operand_1 : $urandom;
        o.offset    = $urandom & 32'hffff_fffe;
        o.pc        = 31'($urandom);
        o.ins_sz    = 1'($urandom);
        c = int'($urandom_range(5));
        // Skip the two unused funct3 codes
        o.cond   = (c < 2) ? 3'(c) : 3'(c + 2);
        o.rob_id = 6'($urandom);
        o.dest   = ($urandom_range(4) == 0) ? 6'd0 : 6'($urandom);
        case (kind)
            1: o.jal = 1'b1;
            2: o.jalr = 1'b1;
            3: o.auipc = 1'b1;
            4: o.call = 1'b1;
            5: o.ret = 1'b1;
            default: ;
        endcase
        o.jal  = o.jal | o.call;
        o.jalr = o.jalr | o.ret;
        return o;
    endfunction

    // Front-end prediction that agrees with the resolved op
    function automatic branch_pkg::btb_pred_t matching_pred(branch_pkg::bru_op_t o);
        branch_pkg::btb_pred_t p;
        core_cfg_pkg::xword_t  tgt;
        tgt       = resolve_target(o, cond_taken(o.operand_1, o.operand_2, o.cond));
        p.present = 1'b1;
        p.btype   = branch_kind(o);
        p.target  = tgt[31:1];
        p.way     = 1'($urandom);
        // Overridden by the table inside the DUT
        p.bm_ctr  = 2'($urandom);
        return p;
    endfunction

    function automatic branch_pkg::btb_pred_t corrupt(branch_pkg::btb_pred_t p, int how);
        branch_pkg::btb_pred_t q;
        q = p;
        case (how)
            1: q.present = 1'b0;
            2: q.btype = branch_pkg::btype_t'(p.btype ^ 2'(1 + $urandom_range(2)));
            3: q.target = p.target ^ (31'd1 << $urandom_range(30));
            default: q = p;
        endcase
        return q;
    endfunction

    // One cycle: drive an op, then check the op sampled one edge earlier
    task automatic step(input branch_pkg::bru_op_t o, input branch_pkg::btb_pred_t p,
                        input logic v, input logic f);
        logic [1:0] ctr;
        @(posedge cpu_clock);
        op    <= o;
        pred  <= p;
        valid <= v;
        flush <= f;
        @(negedge cpu_clock);
        ctr = shadow[o.pc[3:0]];
        ctr_check(bm_ctr, ctr, "bm_ctr_o");
        if (have_prev) begin
            wb_check(wb, prev_exp.wb, "wb_o");
            flag_check(res_valid, prev_exp.res_valid, "res_valid_o");
            rob_check(rob, prev_exp.rob, "rob_o");
            flag_check(excp, prev_exp.excp, "excp_o");
            upd_check(upd, prev_exp.upd, "upd_o");
            // Written at the next edge, after this op has read
            if (prev_exp.upd.bm_mod) begin
                shadow[prev_exp.upd.vpc[3:0]] = ctr_step(prev_exp.upd.bm_ctr, prev_exp.upd.taken);
            end
        end
        prev_exp  = expect_op(o, p, ctr, v, f);
        have_prev = 1'b1;
    endtask

    // Correct hits on one index, spaced so each sees the last write
    task automatic train(input int idx, input bit up, input logic [1:0] sat);
        branch_pkg::bru_op_t o;
        repeat (N_SAT + 1) begin
            o = random_op(up ? 1 : 0);
            o.pc     = {o.pc[30:4], idx[3:0]};
            o.ins_sz = 1'b0;
            if (!up) begin
                // BEQ that never takes
                o.cond      = 3'b000;
                o.operand_2 = o.operand_1 + 32'd1;
            end
            step(o, matching_pred(o), 1'b1, 1'b0);
            step('0, '0, 1'b0, 1'b0);
        end
        // A later op on the same index reads the trained counter
        o = random_op(0);
        o.pc = {o.pc[30:4], idx[3:0]};
        step(o, '0, 1'b0, 1'b0);
        ctr_check(bm_ctr, sat, "bm_ctr_o saturated");
    endtask

    initial begin
        branch_pkg::bru_op_t o;
        void'($urandom(32'h49a8));
        cpu_clock = 1'b0;
        arst_n    = 1'b0;
        valid     = 1'b0;
        flush     = 1'b0;
        op        = '0;
        pred      = '0;
        have_prev = 1'b0;
        err_count = 0;
        for (int i = 0; i < 16; i++) begin
            shadow[i] = 2'b01;
        end
        repeat (RST_CYCLES) @(posedge cpu_clock);
        arst_n <= 1'b1;

        // Downward only works from the reset value
        train(9, 1'b0, 2'b00);
        train(5, 1'b1, 2'b11);

        repeat (N_RAND) begin
            o = random_op(int'($urandom_range(5)));
            step(o, corrupt(matching_pred(o), ($urandom_range(1) == 0) ? 0 : 1 + $urandom_range(2)),
                 $urandom_range(7) != 0, $urandom_range(9) == 0);
        end

        // Compressed ops at every halfword of a fetch block
        for (int pos = 0; pos < 4; pos++) begin
            repeat (2) begin
                o = random_op(int'($urandom_range(1)));
                o.ins_sz  = 1'b1;
                o.pc[1:0] = pos[1:0];
                step(o, matching_pred(o), 1'b1, 1'b0);
            end
        end
        step('0, '0, 1'b0, 1'b0);

        if (err_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            abort_run();
        end
    end

    initial begin
        #((RST_CYCLES + N_STEPS) * 20 + 1000);
        $display("Watchdog timeout, the test sequence did not finish");
        abort_run();
    end

endmodule

//--- tb.f
+incdir+dv
logic/core_cfg_pkg.sv
logic/branch_pkg.sv
logic/branch_compare.sv
logic/branch_target.sv
logic/branch_unit.sv
logic/bimodal_table.sv
logic/branch_exec_top.sv
dv/branch_exec_tb.sv

//--- Makefile
# Verilator flow for the branch execution subsystem
TOP := branch_exec_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f tb.f
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
